// File: Makefile
TOP := tb_ssm_decay

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /Finished with no errors/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+include
verilog/ssm_pkg.sv
verilog/fp16_mul.sv
verilog/dAh_mul.sv
verilog/hstate_buf.sv
verilog/ssm_decay_top.sv
testbench/ssm_decay_checker.sv
testbench/tb_ssm_decay.sv

// File: include/ssm_params.svh
// tile sizes, element width and multiplier latency for the ssm decay tile, include where needed
`ifndef SSM_PARAMS_SVH
`define SSM_PARAMS_SVH

// one fp16 element, slice arithmetic assumes 16
`define SSM_DW 16

// tile shape
`define SSM_H_TILE 1   // heads
`define SSM_P_TILE 2   // channels per head
`define SSM_N_TILE 8   // state entries per channel

// one multiplier lane per (h,p,n)
`define SSM_LANES (`SSM_H_TILE * `SSM_P_TILE * `SSM_N_TILE)

// fp16_mul pipeline depth, 2 or more
`define SSM_MUL_LAT 3

`endif

// File: testbench/ssm_decay_checker.sv
// watches the ssm decay tile ports, models the tile state and checks every step against a reference
`timescale 1ns/10ps
`include "ssm_params.svh"

module ssm_decay_checker (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 load_i,
  input  ssm_pkg::hstate_vec_t state_i,
  input  logic                 step_i,
  input  ssm_pkg::dA_vec_t     dA_i,
  input  ssm_pkg::hstate_vec_t dAh_i,      // uut products
  input  logic                 valid_i,
  input  logic                 busy_i,
  input  ssm_pkg::hstate_vec_t hstate_i,
  input  int                   test_id_i,
  output int                   value_errs_o,
  output int                   proto_errs_o
);

  localparam int DW  = `SSM_DW;
  localparam int LAT = `SSM_MUL_LAT;

  int                   value_errs = 0;
  int                   proto_errs = 0;
  ssm_pkg::hstate_vec_t model_state;    // what hstate should read
  ssm_pkg::hstate_vec_t expect_state;   // products of the step in flight
  logic                 model_busy;
  logic                 pending;
  logic                 idle;
  int                   cyc;
  int                   accept_cyc;
  int                   head;

  function automatic string test_label(input int id);
    case (id)
      0: return "reset";
      1: return "basic_decay";
      2: return "recurrence";
      3: return "special_values";
      4: return "dropped_requests";
      5: return "rounding";
      default: return "unknown";
    endcase
  endfunction

  // --------------------------------------------------
  // reference fp16 multiply, rne with flush to zero
  // --------------------------------------------------
  function automatic ssm_pkg::fp16_t ref_mul(input ssm_pkg::fp16_t a, input ssm_pkg::fp16_t b);
    logic        sgn;
    logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    int unsigned prod;
    int unsigned mant;
    int unsigned rem;
    int unsigned half;
    int          shift;
    int          exp_r;
    sgn    = a[15] ^ b[15];
    a_zero = (a[14:10] == 5'd0);       // subnormal counts as zero
    b_zero = (b[14:10] == 5'd0);
    a_inf  = (a[14:0] == 15'h7c00);
    b_inf  = (b[14:0] == 15'h7c00);
    a_nan  = (a[14:10] == 5'h1f) && !a_inf;
    b_nan  = (b[14:10] == 5'h1f) && !b_inf;
    if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf))
      return 16'h7e00;
    if (a_inf || b_inf)
      return {sgn, 15'h7c00};
    if (a_zero || b_zero)
      return {sgn, 15'h0000};
    prod  = {21'd0, 1'b1, a[9:0]} * {21'd0, 1'b1, b[9:0]};
    shift = (prod >= 32'h0020_0000) ? 11 : 10;    // product below 4, at most one extra bit
    exp_r = int'(a[14:10]) + int'(b[14:10]) - 15 + shift - 10;
    mant  = prod >> shift;
    rem   = prod - (mant << shift);
    half  = 32'd1 << (shift - 1);
    if ((rem > half) || ((rem == half) && (mant % 2 == 1)))
      mant = mant + 1;                 // ties to even
    if (mant == 2048) begin            // carried into next binade
      mant  = 1024;
      exp_r = exp_r + 1;
    end
    if (exp_r >= 31)
      return {sgn, 15'h7c00};
    if (exp_r <= 0)
      return {sgn, 15'h0000};
    return {sgn, 5'(exp_r), 10'(mant)};
  endfunction

  // --------------------------------------------------
  // per-cycle comparison, sampled on the rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    if (rstn) begin
      model_state = '0;
      model_busy  = 1'b0;
      pending     = 1'b0;
      cyc         = 0;
    end else begin
      cyc  = cyc + 1;
      idle = !model_busy;              // decision uses the level before this edge
      if (hstate_i !== model_state) begin
        $display("[FAIL] %s hstate_o: expected %h, actual %h",
                 test_label(test_id_i), model_state, hstate_i);
        value_errs++;
      end
      if (busy_i !== model_busy) begin
        $display("busy_o is %0b at cycle %0d of %s but should be %0b",
                 busy_i, cyc, test_label(test_id_i), model_busy);
        proto_errs++;
      end
      if (valid_i && !pending) begin
        $display("valid_o rose at cycle %0d of %s with no step pending", cyc, test_label(test_id_i));
        proto_errs++;
      end else if (valid_i) begin
        if (cyc - accept_cyc != LAT + 1) begin
          $display("valid_o came %0d cycles after the accepted step in %s instead of %0d",
                   cyc - accept_cyc, test_label(test_id_i), LAT + 1);
          proto_errs++;
        end
        for (int k = 0; k < `SSM_LANES; k++) begin
          if (dAh_i[DW*k +: DW] !== expect_state[DW*k +: DW]) begin
            $display("[FAIL] %s lane %0d: expected %h, actual %h", test_label(test_id_i), k,
                     expect_state[DW*k +: DW], dAh_i[DW*k +: DW]);
            value_errs++;
          end
        end
        model_state = expect_state;    // writeback
        model_busy  = 1'b0;
        pending     = 1'b0;
      end else if (pending && (cyc - accept_cyc == LAT + 2)) begin
        $display("no valid_o for the step accepted at cycle %0d of %s", accept_cyc,
                 test_label(test_id_i));
        proto_errs++;
      end
      if (idle && load_i) begin
        model_state = state_i;         // load wins over a step
      end else if (idle && step_i) begin
        for (int k = 0; k < `SSM_LANES; k++) begin
          head = k / (`SSM_P_TILE * `SSM_N_TILE);
          expect_state[DW*k +: DW] = ref_mul(dA_i[DW*head +: DW], model_state[DW*k +: DW]);
        end
        pending    = 1'b1;
        model_busy = 1'b1;
        accept_cyc = cyc;
      end
    end
  end

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;

endmodule

// File: testbench/tb_ssm_decay.sv
// testbench top for the ssm decay tile, drives loads and decay steps and prints the verdict
`timescale 1ns/10ps
`include "ssm_params.svh"

module tb_ssm_decay;

  localparam int DW        = `SSM_DW;
  localparam int LANES     = `SSM_LANES;
  localparam int LAT       = `SSM_MUL_LAT;
  localparam int N_BASIC   = 4;
  localparam int N_RECUR   = 20;
  localparam int N_SPECIAL = 9;
  localparam int N_DROP    = 4;    // step attempts, dropped ones included
  localparam int N_ROUND   = 30;
  localparam int CYCLE_LIMIT =
    (N_BASIC + N_RECUR + N_SPECIAL + N_DROP + N_ROUND) * (LAT + 4) + 200;

  // subnormal, max, zero, inf, nan and plain words for the special test
  localparam logic [15:0] SPECIAL_H [12] = '{16'h0001, 16'h83ff, 16'h7bff, 16'hfbff,
    16'h0000, 16'h8000, 16'h7c00, 16'hfc00, 16'h7d00, 16'h3c00, 16'h0400, 16'h0401};
  localparam logic [15:0] SPECIAL_DA [9] = '{16'h0000, 16'h8000, 16'hbc00, 16'h7c00,
    16'hfc00, 16'h7e01, 16'h7bff, 16'h0200, 16'h0400};

  logic                 clk = 1'b0;
  logic                 rstn;
  logic                 load_i;
  logic                 step_i;
  ssm_pkg::hstate_vec_t state_i;
  ssm_pkg::dA_vec_t     dA_i;
  ssm_pkg::hstate_vec_t dAh_o;
  ssm_pkg::hstate_vec_t hstate_o;
  logic                 valid_o;
  logic                 busy_o;
  int                   test_id;
  int                   value_errs;
  int                   proto_errs;
  int                   cycle_cnt = 0;
  logic [31:0]          lfsr_q = 32'ha7ac;

  always #20 clk = ~clk;   // 40 ns period

  ssm_decay_top uut (
    .clk (clk), .rstn (rstn), .load_i (load_i), .state_i (state_i), .step_i (step_i),
    .dA_i (dA_i), .dAh_o (dAh_o), .valid_o (valid_o), .busy_o (busy_o), .hstate_o (hstate_o)
  );

  ssm_decay_checker u_check (
    .clk (clk), .rstn (rstn), .load_i (load_i), .state_i (state_i), .step_i (step_i),
    .dA_i (dA_i), .dAh_i (dAh_o), .valid_i (valid_o), .busy_i (busy_o), .hstate_i (hstate_o),
    .test_id_i (test_id), .value_errs_o (value_errs), .proto_errs_o (proto_errs)
  );

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};    // one step per bit
    end
    return v;
  endfunction

  // normal word, exponent field in lo .. lo + 2**span_bits - 1
  function automatic ssm_pkg::fp16_t rand_fp16(input int lo, input int span_bits);
    logic       sgn;
    logic [4:0] ex;
    sgn = 1'(rand_bits(1));
    ex  = 5'(lo + int'(rand_bits(span_bits)));
    return {sgn, ex, 10'(rand_bits(10))};
  endfunction

  function automatic ssm_pkg::hstate_vec_t rand_state(input int lo, input int span_bits);
    ssm_pkg::hstate_vec_t s;
    for (int k = 0; k < LANES; k++) begin
      s[DW*k +: DW] = rand_fp16(lo, span_bits);
    end
    return s;
  endfunction

  function automatic ssm_pkg::dA_vec_t rand_dA(input int lo, input int span_bits);
    ssm_pkg::dA_vec_t d;
    for (int h = 0; h < `SSM_H_TILE; h++) begin
      d[DW*h +: DW] = rand_fp16(lo, span_bits);
    end
    return d;
  endfunction

  // significands that land on or next to a rounding tie
  function automatic ssm_pkg::dA_vec_t tie_dA(input int i);
    ssm_pkg::dA_vec_t d;
    logic [9:0]       m;
    case (i % 6)
      0: m = 10'h200;                 // x1.5, odd partner gives an exact tie
      1: m = 10'h100;
      2: m = 10'h300;
      3: m = 10'h201;                 // just above
      4: m = 10'h1ff;                 // just below
      default: m = 10'(rand_bits(10));
    endcase
    for (int h = 0; h < `SSM_H_TILE; h++) begin
      d[DW*h +: DW] = {1'(rand_bits(1)), 5'd15, m};
    end
    return d;
  endfunction

  function automatic ssm_pkg::hstate_vec_t basic_state();
    ssm_pkg::hstate_vec_t s;
    for (int k = 0; k < LANES; k++) begin
      s[DW*k +: DW] = {1'(k % 2), 5'(13 + k % 5), 10'(k * 97 + 5)};
    end
    return s;
  endfunction

  function automatic ssm_pkg::hstate_vec_t special_state(input int rot);
    ssm_pkg::hstate_vec_t s;
    for (int k = 0; k < LANES; k++) begin
      s[DW*k +: DW] = SPECIAL_H[(k + rot) % 12];
    end
    return s;
  endfunction

  // called at a falling edge, returns at one
  task automatic load_state(input ssm_pkg::hstate_vec_t s);
    load_i  = 1'b1;
    state_i = s;
    @(negedge clk);
    load_i  = 1'b0;
  endtask

  task automatic wait_idle();
    while (busy_o) begin
      @(negedge clk);
    end
  endtask

  task automatic step_and_wait(input ssm_pkg::dA_vec_t d);
    step_i = 1'b1;
    dA_i   = d;
    @(negedge clk);
    step_i = 1'b0;
    wait_idle();                      // busy_o drops after writeback
  endtask

  task automatic print_counts();
    $display("error counts: value %0d, protocol %0d", value_errs, proto_errs);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    rstn    = 1'b1;
    load_i  = 1'b0;
    step_i  = 1'b0;
    state_i = '0;
    dA_i    = '0;
    test_id = 0;
    repeat (8) @(negedge clk);
    rstn = 1'b0;
    repeat (3) @(negedge clk);        // reset values watched by the checker

    test_id = 1;
    load_state(basic_state());
    step_and_wait({`SSM_H_TILE{16'h3800}});   // 0.5
    step_and_wait({`SSM_H_TILE{16'h3b00}});
    step_and_wait({`SSM_H_TILE{16'h3c00}});
    step_and_wait({`SSM_H_TILE{16'hb400}});   // -0.25

    test_id = 2;
    load_state(rand_state(10, 4));
    for (int i = 0; i < N_RECUR; i++) begin
      step_and_wait(rand_dA(13, 1));
    end

    test_id = 3;
    for (int i = 0; i < N_SPECIAL; i++) begin
      load_state(special_state(i));
      step_and_wait({`SSM_H_TILE{SPECIAL_DA[i]}});
    end

    test_id = 4;
    load_state(basic_state());
    step_i = 1'b1;
    dA_i   = {`SSM_H_TILE{16'h3a00}};
    @(negedge clk);
    dA_i   = {`SSM_H_TILE{16'hc000}};  // busy now, dropped
    @(negedge clk);
    step_i  = 1'b0;
    load_i  = 1'b1;                    // load during a step, ignored
    state_i = rand_state(15, 2);
    @(negedge clk);
    load_i = 1'b0;
    wait_idle();
    load_i  = 1'b1;                    // load and step together, load wins
    state_i = rand_state(12, 3);
    step_i  = 1'b1;
    dA_i    = {`SSM_H_TILE{16'h4000}};
    @(negedge clk);
    load_i = 1'b0;
    step_i = 1'b0;
    step_and_wait({`SSM_H_TILE{16'h3d00}});

    test_id = 5;
    for (int i = 0; i < N_ROUND; i++) begin
      load_state(rand_state(14, 2));
      step_and_wait(tie_dA(i));
    end

    repeat (4) @(negedge clk);
    print_counts();
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // run limit from the planned step count
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      print_counts();
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

// File: verilog/dAh_mul.sv
// multiplier bank, dAh(h,p,n) = dA(h) * hprev(h,p,n) over all lanes of the tile
`timescale 1ns/10ps
`include "ssm_params.svh"

module dAh_mul (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 valid_i,
  input  ssm_pkg::dA_vec_t     dA_i,      // one word per head
  input  ssm_pkg::hstate_vec_t hprev_i,   // packed (h,p,n)
  output ssm_pkg::hstate_vec_t dAh_o,     // same packing as hprev_i
  output logic                 valid_o
);

  localparam int DW     = `SSM_DW;
  localparam int H_TILE = `SSM_H_TILE;
  localparam int P_TILE = `SSM_P_TILE;
  localparam int N_TILE = `SSM_N_TILE;
  localparam int LANES  = `SSM_LANES;

  ssm_pkg::fp16_t dA_h       [H_TILE];   // per-head decay words
  ssm_pkg::fp16_t prod       [LANES];    // lane products
  logic           lane_valid [LANES];

  genvar h, p, n;
  generate
    for (h = 0; h < H_TILE; h++) begin : g_dA
      assign dA_h[h] = dA_i[DW*h +: DW];
    end

    for (h = 0; h < H_TILE; h++) begin : g_h
      for (p = 0; p < P_TILE; p++) begin : g_p
        for (n = 0; n < N_TILE; n++) begin : g_n
          localparam int IDX = (h*P_TILE + p)*N_TILE + n;

          fp16_mul u_mul (
            .clk      (clk),
            .rstn     (rstn),
            .valid_i  (valid_i),
            .a_i      (dA_h[h]),                 // broadcast over (p,n)
            .b_i      (hprev_i[DW*IDX +: DW]),
            .result_o (prod[IDX]),
            .valid_o  (lane_valid[IDX])
          );
        end
      end
    end
  endgenerate

  // pack products back, lane 0 in the low word
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      dAh_o[DW*k +: DW] = prod[k];
    end
  end

  // all lanes share one latency, lane 0 speaks for the bank
  assign valid_o = lane_valid[0];

endmodule

// File: verilog/fp16_mul.sv
// one pipelined fp16 multiplier lane (rne, ftz, inf saturation), instanced per lane by dAh_mul
`timescale 1ns/10ps
`include "ssm_params.svh"

module fp16_mul (
  input  logic           clk,
  input  logic           rstn,
  input  logic           valid_i,
  input  ssm_pkg::fp16_t a_i,
  input  ssm_pkg::fp16_t b_i,
  output ssm_pkg::fp16_t result_o,
  output logic           valid_o
);

  localparam int LAT = `SSM_MUL_LAT;

  // --------------------------------------------------
  // stage 1 unpack, classify, significand multiply
  // --------------------------------------------------
  logic       sa;
  logic       sb;
  logic [4:0] ea;
  logic [4:0] eb;
  logic [9:0] ma;
  logic [9:0] mb;
  logic       a_zero;
  logic       b_zero;
  logic       a_inf;
  logic       b_inf;
  logic       a_nan;
  logic       b_nan;

  assign sa = a_i[15];
  assign sb = b_i[15];
  assign ea = a_i[14:10];
  assign eb = b_i[14:10];
  assign ma = a_i[9:0];
  assign mb = b_i[9:0];

  assign a_zero = (ea == 5'd0);                  // zero or subnormal, both flushed
  assign b_zero = (eb == 5'd0);
  assign a_inf  = (ea == 5'h1f) && (ma == 10'd0);
  assign b_inf  = (eb == 5'h1f) && (mb == 10'd0);
  assign a_nan  = (ea == 5'h1f) && (ma != 10'd0);
  assign b_nan  = (eb == 5'h1f) && (mb != 10'd0);

  logic              s1_sign;
  logic [21:0]       s1_prod;   // 1.10 x 1.10, top bit at 21 or 20
  logic signed [7:0] s1_exp;    // unbiased sum plus bias, may go negative
  logic              s1_nan;
  logic              s1_inf;
  logic              s1_zero;

  always_ff @(posedge clk) begin
    s1_sign <= sa ^ sb;
    s1_prod <= {1'b1, ma} * {1'b1, mb};
    s1_exp  <= $signed({3'b000, ea}) + $signed({3'b000, eb}) - 8'sd15;
    s1_nan  <= a_nan | b_nan | (a_zero & b_inf) | (a_inf & b_zero);  // 0*inf too
    s1_inf  <= a_inf | b_inf;
    s1_zero <= a_zero | b_zero;
  end

  // --------------------------------------------------
  // stage 2 normalise and round to nearest even
  // --------------------------------------------------
  logic [9:0]        n_man;
  logic              n_guard;
  logic              n_sticky;
  logic signed [7:0] n_exp;
  logic              round_up;
  logic [10:0]       r_man;     // bit 10 is the rounding carry

  always_comb begin
    if (s1_prod[21]) begin              // product in [2,4), shift by one
      n_man    = s1_prod[20:11];
      n_guard  = s1_prod[10];
      n_sticky = |s1_prod[9:0];
      n_exp    = s1_exp + 8'sd1;
    end else begin
      n_man    = s1_prod[19:10];
      n_guard  = s1_prod[9];
      n_sticky = |s1_prod[8:0];
      n_exp    = s1_exp;
    end
    round_up = n_guard & (n_sticky | n_man[0]);  // ties go to even
    r_man    = {1'b0, n_man} + {10'd0, round_up};
  end

  logic              s2_sign;
  logic signed [7:0] s2_exp;
  logic [9:0]        s2_man;
  logic              s2_nan;
  logic              s2_inf;
  logic              s2_zero;

  always_ff @(posedge clk) begin
    s2_sign <= s1_sign;
    s2_exp  <= r_man[10] ? n_exp + 8'sd1 : n_exp;  // mantissa wrapped to zero
    s2_man  <= r_man[9:0];
    s2_nan  <= s1_nan;
    s2_inf  <= s1_inf;
    s2_zero <= s1_zero;
  end

  // --------------------------------------------------
  // stage 3 range limits and special cases
  // --------------------------------------------------
  ssm_pkg::fp16_t fin;

  always_comb begin
    if (s2_nan)
      fin = 16'h7e00;                        // canonical qnan
    else if (s2_inf)
      fin = {s2_sign, 5'h1f, 10'd0};
    else if (s2_zero)
      fin = {s2_sign, 15'd0};
    else if (s2_exp >= 8'sd31)
      fin = {s2_sign, 5'h1f, 10'd0};         // overflow saturates to inf
    else if (s2_exp <= 8'sd0)
      fin = {s2_sign, 15'd0};                // subnormal result flushed
    else
      fin = {s2_sign, s2_exp[4:0], s2_man};
  end

  // extra stages only delay the result
  generate
    if (LAT > 2) begin : g_delay
      ssm_pkg::fp16_t dly_q [LAT-2];
      always_ff @(posedge clk) begin
        dly_q[0] <= fin;
        for (int i = 1; i < LAT-2; i++) begin
          dly_q[i] <= dly_q[i-1];
        end
      end
      assign result_o = dly_q[LAT-3];
    end else begin : g_no_delay
      assign result_o = fin;                 // stage 3 folds into the output
    end
  endgenerate

  // valid shift register, LAT deep
  logic [LAT-1:0] valid_sr;

  always_ff @(posedge clk) begin
    if (rstn) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[LAT-2:0], valid_i};
    end
  end

  assign valid_o = valid_sr[LAT-1];

endmodule

// File: verilog/hstate_buf.sv
// tile state register, takes loads, issues one decay step at a time and stores the products
`timescale 1ns/10ps

module hstate_buf (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 load_i,      // strobe with state_i
  input  ssm_pkg::hstate_vec_t state_i,
  input  logic                 step_i,      // strobe with dA_i
  input  ssm_pkg::dA_vec_t     dA_i,
  input  logic                 wb_valid_i,  // bank result ready
  input  ssm_pkg::hstate_vec_t wb_state_i,
  output logic                 issue_o,
  output ssm_pkg::hstate_vec_t hprev_o,     // also the visible state
  output ssm_pkg::dA_vec_t     dA_o,
  output logic                 busy_o
);

  ssm_pkg::buf_state_e  st_q;
  ssm_pkg::hstate_vec_t state_q;
  ssm_pkg::dA_vec_t     dA_q;
  logic                 issue_q;
  logic                 accept;

  // load wins over step, steps in flight are dropped
  assign accept = (st_q == ssm_pkg::IDLE) && step_i && !load_i;

  always_ff @(posedge clk) begin
    if (rstn) begin
      st_q    <= ssm_pkg::IDLE;
      state_q <= '0;
      issue_q <= 1'b0;
    end else begin
      issue_q <= accept;                       // one-cycle issue pulse
      case (st_q)
        ssm_pkg::IDLE: begin
          if (load_i) begin
            state_q <= state_i;
          end else if (accept) begin
            st_q <= ssm_pkg::WAIT_MUL;
          end
        end
        ssm_pkg::WAIT_MUL: begin
          if (wb_valid_i) begin                // writeback and release
            state_q <= wb_state_i;
            st_q    <= ssm_pkg::IDLE;
          end
        end
        default: st_q <= ssm_pkg::IDLE;
      endcase
    end
  end

  // decay held for the issue cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      dA_q <= dA_i;
    end
  end

  assign issue_o = issue_q;
  assign hprev_o = state_q;
  assign dA_o    = dA_q;
  assign busy_o  = (st_q == ssm_pkg::WAIT_MUL);

endmodule

// File: verilog/ssm_decay_top.sv
// ssm decay tile top, state buffer feeding the fp16 multiplier bank with writeback
`timescale 1ns/10ps

module ssm_decay_top (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 load_i,
  input  ssm_pkg::hstate_vec_t state_i,
  input  logic                 step_i,
  input  ssm_pkg::dA_vec_t     dA_i,
  output ssm_pkg::hstate_vec_t dAh_o,
  output logic                 valid_o,
  output logic                 busy_o,
  output ssm_pkg::hstate_vec_t hstate_o
);

  // --------------------------------------------------
  // buffer to bank
  // --------------------------------------------------
  logic                 issue;
  ssm_pkg::hstate_vec_t hprev;
  ssm_pkg::dA_vec_t     dA_reg;

  // bank results, shared by writeback and outputs
  ssm_pkg::hstate_vec_t prod;
  logic                 prod_valid;

  hstate_buf u_buf (
    .clk        (clk),
    .rstn       (rstn),
    .load_i     (load_i),
    .state_i    (state_i),
    .step_i     (step_i),
    .dA_i       (dA_i),
    .wb_valid_i (prod_valid),
    .wb_state_i (prod),
    .issue_o    (issue),
    .hprev_o    (hprev),
    .dA_o       (dA_reg),
    .busy_o     (busy_o)
  );

  dAh_mul u_bank (
    .clk     (clk),
    .rstn    (rstn),
    .valid_i (issue),
    .dA_i    (dA_reg),
    .hprev_i (hprev),
    .dAh_o   (prod),
    .valid_o (prod_valid)
  );

  assign dAh_o    = prod;
  assign valid_o  = prod_valid;
  assign hstate_o = hprev;   // stored state

endmodule

// File: verilog/ssm_pkg.sv
// shared types of the ssm decay tile, referenced from the rtl as ssm_pkg::name
`include "ssm_params.svh"

package ssm_pkg;

  // one ieee half-precision word
  typedef logic [`SSM_DW-1:0] fp16_t;

  // per-head decay, head 0 in the low word
  typedef logic [`SSM_H_TILE*`SSM_DW-1:0] dA_vec_t;

  // tile state, word index ((h*P_TILE + p)*N_TILE + n), index 0 low
  typedef logic [`SSM_LANES*`SSM_DW-1:0] hstate_vec_t;

  // state buffer phases
  typedef enum logic {
    IDLE,      // ready for load or step
    WAIT_MUL   // step in the multiplier bank
  } buf_state_e;

endpackage
